// ==== Makefile ====
# Verilator build and run for the memory maintenance testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_maint
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/maint_pkg.sv ====
// memory maintenance shared definitions
// widths, region sizes and the init phase encoding

`default_nettype none

package maint_pkg;

    // data path
    localparam int WORD_W = 32;
    localparam int BE_W   = WORD_W / 8;     // one enable per byte

    // byte addressing into the controller
    localparam int MEM_ADDR_W = 12;
    localparam logic [MEM_ADDR_W-1:0] ADDR_STEP = MEM_ADDR_W'(BE_W);

    // zero fill covers the whole region
    localparam int MEM_BYTES = 1024;        // 256 words

    // boot image lands at address 0, verify walks the same span
    localparam int LOAD_BYTES = 256;        // 64 words

    // loader has no back-pressure, so a few words of slack
    localparam int FIFO_DEPTH = 4;

    // init phases, in the order they run
    typedef enum logic [2:0] {
        PH_CALIB  = 3'd0,   // waiting on controller calibration
        PH_ZERO   = 3'd1,
        PH_LOAD   = 3'd2,
        PH_VERIFY = 3'd3,
        PH_READY  = 3'd4    // cpu owns the bus
    } phase_t;

endpackage

`default_nettype wire

// ==== filelist.f ====
common/maint_pkg.sv
logic/word_fifo.sv
init_seq/checksum_unit.sv
init_seq/init_sequencer.sv
init_seq/mem_maint_top.sv
sim/mem_model.sv
sim/tb_mem_maint.sv

// ==== init_seq/checksum_unit.sv ====
// load and verify checksums
// two modulo 2^32 accumulators, match flag compares them

`default_nettype none

module checksum_unit (
    input  wire                         clk,
    input  wire                         i_reset,
    input  wire                         i_load_add,
    input  wire                         i_verify_add,
    input  wire [maint_pkg::WORD_W-1:0] i_add_data,
    output logic                        o_sums_match
);

    logic [maint_pkg::WORD_W-1:0] load_sum;
    logic [maint_pkg::WORD_W-1:0] verify_sum;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            load_sum   <= '0;
            verify_sum <= '0;
        end else begin
            // sum of words written during load
            if (i_load_add) begin
                load_sum <= load_sum + i_add_data;
            end
            if (i_verify_add) begin
                verify_sum <= verify_sum + i_add_data;  // readback
            end
        end
    end

    // only meaningful once verify has walked the whole region
    assign o_sums_match = (load_sum == verify_sum);

    // a single completion per cycle, load and verify never overlap
    a_one_add: assert property (@(posedge clk) disable iff (i_reset)
        !(i_load_add && i_verify_add))
        else $error("checksum_unit: load and verify add together");

endmodule

`default_nettype wire

// ==== init_seq/init_sequencer.sv ====
// init sequencer for the memory maintenance block
// zero fill, boot image load and readback verify over the controller
// busy handshake, then hands the bus to the cpu

`default_nettype none

module init_sequencer (
    input  wire                             clk,
    input  wire                             i_reset,
    input  wire                             i_calib_done,
    input  wire                             i_fifo_valid,
    input  wire [maint_pkg::WORD_W-1:0]     i_fifo_data,
    input  wire                             i_rd_en,
    input  wire                             i_wr_en,
    input  wire [maint_pkg::MEM_ADDR_W-1:0] i_addr,
    input  wire [maint_pkg::WORD_W-1:0]     i_wdata,
    input  wire [maint_pkg::BE_W-1:0]       i_be,
    input  wire                             i_mem_busy,
    input  wire [maint_pkg::WORD_W-1:0]     i_mem_rdata,
    input  wire                             i_sums_match,
    output logic                            o_fifo_pop,
    output logic                            o_load_add,
    output logic                            o_verify_add,
    output logic [maint_pkg::WORD_W-1:0]    o_add_data,
    output logic                            o_mem_rd_en,
    output logic                            o_mem_wr_en,
    output logic [maint_pkg::MEM_ADDR_W-1:0] o_mem_addr,
    output logic [maint_pkg::WORD_W-1:0]    o_mem_wdata,
    output logic [maint_pkg::BE_W-1:0]      o_mem_be,
    output logic [maint_pkg::WORD_W-1:0]    o_rdata,
    output logic                            o_busy,
    output logic                            o_init_done,
    output logic                            o_verify_ok
);

    // handshake substate for one memory operation
    typedef enum logic [1:0] {
        ST_ISSUE   = 2'd0,
        ST_WAIT_HI = 2'd1,  // request up, waiting for busy
        ST_WAIT_LO = 2'd2   // busy seen, waiting for completion
    } hs_t;

    maint_pkg::phase_t phase;
    maint_pkg::phase_t next_phase;
    hs_t               hs;

    logic [maint_pkg::MEM_ADDR_W-1:0] addr;
    logic [maint_pkg::WORD_W-1:0]     wr_data;
    logic                             req_wr;
    logic                             req_rd;
    logic                             ready;
    logic                             want_issue;
    logic                             last_word;
    logic                             issue;
    logic                             done;

    assign ready = (phase == maint_pkg::PH_READY);

    // what each phase wants and where it ends
    always_comb begin
        want_issue = 1'b0;
        last_word  = 1'b0;
        next_phase = phase;
        case (phase)
            maint_pkg::PH_ZERO: begin
                want_issue = 1'b1;
                last_word  = (32'(addr) ==
                              maint_pkg::MEM_BYTES - 32'(maint_pkg::ADDR_STEP));
                next_phase = maint_pkg::PH_LOAD;
            end
            maint_pkg::PH_LOAD: begin
                want_issue = i_fifo_valid;  // wait for loader words
                last_word  = (32'(addr) ==
                              maint_pkg::LOAD_BYTES - 32'(maint_pkg::ADDR_STEP));
                next_phase = maint_pkg::PH_VERIFY;
            end
            maint_pkg::PH_VERIFY: begin
                want_issue = 1'b1;
                last_word  = (32'(addr) ==
                              maint_pkg::LOAD_BYTES - 32'(maint_pkg::ADDR_STEP));
                next_phase = maint_pkg::PH_READY;
            end
            default: ;
        endcase
    end

    assign issue = (hs == ST_ISSUE) && want_issue && !i_mem_busy;
    assign done  = (hs == ST_WAIT_LO) && !i_mem_busy;

    // pop with the load issue, drain stray words once loading is over
    assign o_fifo_pop = (issue && phase == maint_pkg::PH_LOAD) ||
                        (i_fifo_valid && (phase == maint_pkg::PH_VERIFY || ready));

    assign o_load_add   = done && (phase == maint_pkg::PH_LOAD);
    assign o_verify_add = done && (phase == maint_pkg::PH_VERIFY);
    assign o_add_data   = (phase == maint_pkg::PH_VERIFY) ? i_mem_rdata : wr_data;

    always_ff @(posedge clk) begin
        if (issue) begin
            wr_data <= (phase == maint_pkg::PH_LOAD) ? i_fifo_data : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            phase       <= maint_pkg::PH_CALIB;
            hs          <= ST_ISSUE;
            addr        <= '0;
            req_wr      <= 1'b0;
            req_rd      <= 1'b0;
            o_init_done <= 1'b0;
            o_verify_ok <= 1'b0;
        end else begin
            case (hs)
                ST_ISSUE: begin
                    if (issue) begin
                        req_wr <= (phase != maint_pkg::PH_VERIFY);
                        req_rd <= (phase == maint_pkg::PH_VERIFY);
                        hs     <= ST_WAIT_HI;
                    end
                end
                ST_WAIT_HI: begin
                    if (i_mem_busy) begin  // controller took it
                        req_wr <= 1'b0;
                        req_rd <= 1'b0;
                        hs     <= ST_WAIT_LO;
                    end
                end
                ST_WAIT_LO: begin
                    if (!i_mem_busy) begin
                        hs <= ST_ISSUE;
                        if (last_word) begin
                            addr  <= '0;
                            phase <= next_phase;
                        end else begin
                            addr <= addr + maint_pkg::ADDR_STEP;
                        end
                    end
                end
                default: hs <= ST_ISSUE;
            endcase

            if (phase == maint_pkg::PH_CALIB && i_calib_done) begin
                phase <= maint_pkg::PH_ZERO;
            end

            // first ready cycle, last verify add already summed
            if (ready && !o_init_done) begin
                o_init_done <= 1'b1;
                o_verify_ok <= i_sums_match;
            end
        end
    end

    // memory port, cpu only in the ready phase
    assign o_mem_wr_en = ready ? i_wr_en : req_wr;
    assign o_mem_rd_en = ready ? i_rd_en : req_rd;
    assign o_mem_addr  = ready ? i_addr  : addr;
    assign o_mem_wdata = ready ? i_wdata : wr_data;
    assign o_mem_be    = ready ? i_be    : '1;  // full words during init
    assign o_busy      = ready ? i_mem_busy : 1'b1;
    assign o_rdata     = ready ? i_mem_rdata : '0;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (i_reset)
        !(o_mem_wr_en && o_mem_rd_en))
        else $error("init_sequencer: read and write together");

    // controller must stay idle until our request is seen
    a_issue_idle: assert property (@(posedge clk) disable iff (i_reset)
        $rose(req_wr || req_rd) |-> !i_mem_busy && $past(!i_mem_busy))
        else $error("init_sequencer: request raised while busy");

endmodule

`default_nettype wire

// ==== init_seq/mem_maint_top.sv ====
// memory maintenance top level
// loader fifo, init sequencer and checksum unit in front of the memory controller

`default_nettype none

module mem_maint_top (
    input  wire                              clk,
    input  wire                              i_reset,
    input  wire                              i_calib_done,
    input  wire                              i_load_strobe,
    input  wire [maint_pkg::WORD_W-1:0]      i_load_data,
    input  wire                              i_rd_en,
    input  wire                              i_wr_en,
    input  wire [maint_pkg::MEM_ADDR_W-1:0]  i_addr,
    input  wire [maint_pkg::WORD_W-1:0]      i_wdata,
    input  wire [maint_pkg::BE_W-1:0]        i_be,
    input  wire                              i_mem_busy,
    input  wire [maint_pkg::WORD_W-1:0]      i_mem_rdata,
    output wire [maint_pkg::WORD_W-1:0]      o_rdata,
    output wire                              o_busy,
    output wire                              o_mem_rd_en,
    output wire                              o_mem_wr_en,
    output wire [maint_pkg::MEM_ADDR_W-1:0]  o_mem_addr,
    output wire [maint_pkg::WORD_W-1:0]      o_mem_wdata,
    output wire [maint_pkg::BE_W-1:0]        o_mem_be,
    output wire                              o_init_done,
    output wire                              o_verify_ok,
    output wire                              o_load_overflow
);

    wire                         fifo_valid;
    wire [maint_pkg::WORD_W-1:0] fifo_data;
    wire                         fifo_pop;
    wire                         load_add;
    wire                         verify_add;
    wire [maint_pkg::WORD_W-1:0] add_data;
    wire                         sums_match;

    // every loader strobe goes in, the sequencer decides what to keep
    word_fifo #(
        .WIDTH (maint_pkg::WORD_W),
        .DEPTH (maint_pkg::FIFO_DEPTH)
    ) word_fifo_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_push      (i_load_strobe),
        .i_push_data (i_load_data),
        .i_pop       (fifo_pop),
        .o_valid     (fifo_valid),
        .o_data      (fifo_data),
        .o_overflow  (o_load_overflow)
    );

    init_sequencer init_sequencer_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_calib_done (i_calib_done),
        .i_fifo_valid (fifo_valid),
        .i_fifo_data  (fifo_data),
        .i_rd_en      (i_rd_en),
        .i_wr_en      (i_wr_en),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_be         (i_be),
        .i_mem_busy   (i_mem_busy),
        .i_mem_rdata  (i_mem_rdata),
        .i_sums_match (sums_match),
        .o_fifo_pop   (fifo_pop),
        .o_load_add   (load_add),
        .o_verify_add (verify_add),
        .o_add_data   (add_data),
        .o_mem_rd_en  (o_mem_rd_en),
        .o_mem_wr_en  (o_mem_wr_en),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .o_mem_be     (o_mem_be),
        .o_rdata      (o_rdata),
        .o_busy       (o_busy),
        .o_init_done  (o_init_done),
        .o_verify_ok  (o_verify_ok)
    );

    checksum_unit checksum_unit_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_load_add   (load_add),
        .i_verify_add (verify_add),
        .i_add_data   (add_data),
        .o_sums_match (sums_match)
    );

endmodule

`default_nettype wire

// ==== logic/word_fifo.sv ====
// word fifo for the loader stream
// circular buffer, drops pushes when full and latches a sticky overflow

`default_nettype none

module word_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  wire              clk,
    input  wire              i_reset,
    input  wire              i_push,
    input  wire [WIDTH-1:0]  i_push_data,
    input  wire              i_pop,
    output logic             o_valid,
    output logic [WIDTH-1:0] o_data,
    output logic             o_overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = i_push && !full;
    assign do_pop  = i_pop && o_valid;
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];  // head word, valid with o_valid

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // word lost, held until reset
            if (i_push && full) begin
                o_overflow <= 1'b1;
            end
        end
    end

    // consumer must only pop a word it has seen
    a_no_pop_empty: assert property (@(posedge clk) disable iff (i_reset)
        i_pop |-> o_valid)
        else $error("word_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== sim/mem_model.sv ====
// memory controller model for the testbench
// busy handshake with random 1 to 4 busy cycles, byte-lane writes,
// per-word write counts and an optional corrupted readback address

`default_nettype none

module mem_model #(
    parameter logic [maint_pkg::MEM_ADDR_W-1:0] CORRUPT_ADDR = 12'h020
) (
    input  wire                             clk,
    input  wire                             i_reset,
    input  wire                             i_rd_en,
    input  wire                             i_wr_en,
    input  wire [maint_pkg::MEM_ADDR_W-1:0] i_addr,
    input  wire [maint_pkg::WORD_W-1:0]     i_wdata,
    input  wire [maint_pkg::BE_W-1:0]       i_be,
    input  wire                             i_corrupt,
    output logic                            o_busy,
    output logic [maint_pkg::WORD_W-1:0]    o_rdata,
    output int                              o_writes,
    output int                              o_reads
);

    localparam int LSB   = $clog2(maint_pkg::BE_W);
    localparam int WORDS = 1 << (maint_pkg::MEM_ADDR_W - LSB);

    logic [maint_pkg::WORD_W-1:0] mem [WORDS];
    int unsigned                  wr_count [WORDS];
    logic [maint_pkg::MEM_ADDR_W-LSB-1:0] widx;
    logic [2:0]                   hold;     // busy cycles left after this one
    integer                       seed = 32'hdfe2b7f0;

    assign widx = i_addr[maint_pkg::MEM_ADDR_W-1:LSB];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_busy   <= 1'b0;
            o_rdata  <= '0;
            o_writes <= 0;
            o_reads  <= 0;
            hold     <= '0;
            for (int i = 0; i < WORDS; i++) begin
                mem[i]      <= 32'hc0de_0000 | maint_pkg::WORD_W'(i);  // whole index in the fill
                wr_count[i] <= 0;
            end
        end else if (o_busy) begin
            if (hold == '0) begin
                o_busy <= 1'b0;
            end else begin
                hold <= hold - 1'b1;
            end
        end else if (i_wr_en || i_rd_en) begin
            o_busy <= 1'b1;
            hold   <= 3'($unsigned($random(seed)) % 4);
            if (i_wr_en) begin
                for (int b = 0; b < maint_pkg::BE_W; b++) begin
                    if (i_be[b]) begin
                        mem[widx][8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
                wr_count[widx] <= wr_count[widx] + 1;
                o_writes       <= o_writes + 1;
            end else begin
                // held until the next read, so valid at completion
                o_rdata <= (i_corrupt && i_addr == CORRUPT_ADDR) ? ~mem[widx] : mem[widx];
                o_reads <= o_reads + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_mem_maint.sv ====
// testbench for the memory maintenance block
// two init runs against the memory model with corrupted readback in the second
// and a cpu write and read through the ready-phase bus

`default_nettype none

module tb_mem_maint;

    localparam int STEP       = int'(maint_pkg::ADDR_STEP);
    localparam int ZERO_WORDS = maint_pkg::MEM_BYTES / STEP;
    localparam int LOAD_WORDS = maint_pkg::LOAD_BYTES / STEP;
    // two runs at up to 8 cycles per memory op with 3x margin plus reset and cpu slack
    localparam int WATCHDOG_CYCLES = 3 * 2 * (ZERO_WORDS + 2 * LOAD_WORDS) * 8 + 1000;
    localparam logic [maint_pkg::MEM_ADDR_W-1:0] CPU_ADDR = 12'h010;   // word 4

    logic clk = 1'b0;
    logic reset;
    logic calib_done;
    logic load_strobe;
    logic [maint_pkg::WORD_W-1:0] load_data;
    logic rd_en;
    logic wr_en;
    logic [maint_pkg::MEM_ADDR_W-1:0] addr;
    logic [maint_pkg::WORD_W-1:0] wdata;
    logic [maint_pkg::BE_W-1:0] be;
    logic corrupt;
    logic calib_wait;   // high from reset release until calibration is given

    wire [maint_pkg::WORD_W-1:0] rdata;
    wire [maint_pkg::WORD_W-1:0] mem_rdata;
    wire [maint_pkg::WORD_W-1:0] mem_wdata;
    wire [maint_pkg::MEM_ADDR_W-1:0] mem_addr;
    wire [maint_pkg::BE_W-1:0] mem_be;
    wire busy;
    wire mem_busy;
    wire mem_rd_en;
    wire mem_wr_en;
    wire init_done;
    wire verify_ok;
    wire load_overflow;
    int  writes;
    int  reads;

    logic [maint_pkg::WORD_W-1:0] load_words [LOAD_WORDS];
    integer seed = 32'hdfe2b7f0;
    int errors = 0;
    int errors_seen = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #50 clk = ~clk;

    mem_maint_top mem_maint_top_inst (
        .clk (clk), .i_reset (reset), .i_calib_done (calib_done),
        .i_load_strobe (load_strobe), .i_load_data (load_data),
        .i_rd_en (rd_en), .i_wr_en (wr_en), .i_addr (addr), .i_wdata (wdata), .i_be (be),
        .i_mem_busy (mem_busy), .i_mem_rdata (mem_rdata),
        .o_rdata (rdata), .o_busy (busy), .o_mem_rd_en (mem_rd_en), .o_mem_wr_en (mem_wr_en),
        .o_mem_addr (mem_addr), .o_mem_wdata (mem_wdata), .o_mem_be (mem_be),
        .o_init_done (init_done), .o_verify_ok (verify_ok), .o_load_overflow (load_overflow)
    );

    mem_model mem_model_inst (
        .clk (clk), .i_reset (reset), .i_rd_en (mem_rd_en), .i_wr_en (mem_wr_en),
        .i_addr (mem_addr), .i_wdata (mem_wdata), .i_be (mem_be), .i_corrupt (corrupt),
        .o_busy (mem_busy), .o_rdata (mem_rdata), .o_writes (writes), .o_reads (reads)
    );

    a_reset_state: assert property (@(posedge clk)
        ($past(reset) || calib_wait) |->
            (!mem_wr_en && !mem_rd_en && busy && !init_done))
        else begin
            $display("Fail t=%0t wr/rd/o_busy/o_init_done got %b%b%b%b exp 0010",
                     $time, mem_wr_en, mem_rd_en, busy, init_done);
            errors++;
        end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !load_overflow)
        else begin
            $display("Fail t=%0t o_load_overflow got %b exp 0", $time, load_overflow);
            errors++;
        end

    // the first ZERO_WORDS writes are the zero fill
    a_zero_write: assert property (@(posedge clk) disable iff (reset)
        (mem_wr_en && !mem_busy && writes < ZERO_WORDS) |->
            (mem_wdata == '0 && mem_be == '1))
        else begin
            $display("Fail t=%0t o_mem_wdata got %h exp 0, o_mem_be got %b exp 1111",
                     $time, mem_wdata, mem_be);
            errors++;
        end

    a_reads_at_done: assert property (@(posedge clk) disable iff (reset)
        $rose(init_done) |-> reads == LOAD_WORDS)
        else begin
            $display("Fail t=%0t reads at o_init_done got %0d exp %0d",
                     $time, reads, LOAD_WORDS);
            errors++;
        end

    a_pass_req: assert property (@(posedge clk) disable iff (reset)
        init_done |-> (mem_wr_en == wr_en && mem_rd_en == rd_en && mem_addr == addr &&
                       mem_wdata == wdata && mem_be == be))
        else begin
            $write("Fail t=%0t o_mem_wr_en/rd_en got %b%b exp %b%b, o_mem_addr got %h exp %h",
                   $time, mem_wr_en, mem_rd_en, wr_en, rd_en, mem_addr, addr);
            $display(", o_mem_wdata got %h exp %h, o_mem_be got %b exp %b",
                     mem_wdata, wdata, mem_be, be);
            errors++;
        end

    a_pass_resp: assert property (@(posedge clk) disable iff (reset)
        init_done |-> (busy == mem_busy && rdata == mem_rdata))
        else begin
            $display("Fail t=%0t o_busy got %b exp %b, o_rdata got %h exp %h",
                     $time, busy, mem_busy, rdata, mem_rdata);
            errors++;
        end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] lanes);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < maint_pkg::BE_W; b++) begin
            if (lanes[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic apply_reset(input logic corrupt_read);
        reset      <= 1'b1;
        calib_done <= 1'b0;
        corrupt    <= corrupt_read;
        repeat (10) @(posedge clk);
        reset      <= 1'b0;
        calib_wait <= 1'b1;
        repeat (5) @(posedge clk);
        calib_wait <= 1'b0;
        calib_done <= 1'b1;
    endtask

    task automatic check_zero_fill;
        while (writes < ZERO_WORDS) @(posedge clk);
        for (int k = 0; k < ZERO_WORDS; k++) begin
            assert (mem_model_inst.wr_count[k] == 1 && mem_model_inst.mem[k] == '0) else begin
                $display("Fail t=%0t word %0d writes got %0d exp 1, data got %h exp 0",
                         $time, k, mem_model_inst.wr_count[k], mem_model_inst.mem[k]);
                errors++;
            end
        end
    endtask

    task automatic feed_loader;
        for (int k = 0; k < LOAD_WORDS; k++) begin
            load_words[k] = $random(seed);
            load_strobe <= 1'b1;
            load_data   <= load_words[k];
            @(posedge clk);
            load_strobe <= 1'b0;
            repeat (7) @(posedge clk);   // one strobe every 8 cycles
        end
        while (!init_done) @(posedge clk);
    endtask

    task automatic check_load;
        logic [31:0] exp;
        for (int k = 0; k < ZERO_WORDS; k++) begin
            exp = (k < LOAD_WORDS) ? load_words[k] : '0;
            assert (mem_model_inst.mem[k] == exp) else begin
                $display("Fail t=%0t mem[%0d] got %h exp %h",
                         $time, k, mem_model_inst.mem[k], exp);
                errors++;
            end
        end
    endtask

    task automatic cpu_access(input logic write, input logic [11:0] a, input logic [31:0] d,
                              input logic [3:0] lanes, output logic [31:0] data);
        wr_en <= write;
        rd_en <= !write;
        addr  <= a;
        wdata <= d;
        be    <= lanes;
        @(posedge clk);
        while (!busy) @(posedge clk);
        wr_en <= 1'b0;   // drop the request once busy is seen
        rd_en <= 1'b0;
        while (busy) @(posedge clk);
        data = rdata;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_seen) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_seen);
        end
        errors_seen = errors;
    endtask

    initial begin
        logic [31:0] got;
        logic [31:0] merged;
        reset       <= 1'b1;
        calib_done  <= 1'b0;
        calib_wait  <= 1'b0;
        load_strobe <= 1'b0;
        load_data   <= '0;
        rd_en       <= 1'b0;
        wr_en       <= 1'b0;
        addr        <= '0;
        wdata       <= '0;
        be          <= '0;
        corrupt     <= 1'b0;
        apply_reset(1'b0);
        report_test("reset state");
        check_zero_fill();
        report_test("zero fill");
        feed_loader();
        check_load();
        report_test("load");
        assert (verify_ok) else begin
            $display("Fail t=%0t o_verify_ok got %b exp 1", $time, verify_ok);
            errors++;
        end
        report_test("verify pass");
        merged = merge_bytes(load_words[CPU_ADDR / STEP], 32'h1122_3344, 4'b0101);
        cpu_access(1'b1, CPU_ADDR, 32'h1122_3344, 4'b0101, got);
        cpu_access(1'b0, CPU_ADDR, '0, 4'b1111, got);
        assert (got == merged) else begin
            $display("Fail t=%0t o_rdata got %h exp %h", $time, got, merged);
            errors++;
        end
        report_test("pass-through");
        apply_reset(1'b1);   // second run with one readback word inverted
        check_zero_fill();
        feed_loader();
        assert (!verify_ok) else begin
            $display("Fail t=%0t o_verify_ok got %b exp 0", $time, verify_ok);
            errors++;
        end
        report_test("verify fail");
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
